// ==== rtl/rxsdu_pkg.sv ====
`default_nettype none

package rxsdu_pkg;

    // ======================================================================
    // Frame word
    // ======================================================================

    // One 18-bit channel word
    // sop in bit 17, eop in bit 16, payload below
    typedef struct packed {
        logic        sop;
        logic        eop;
        logic [15:0] payload;
    } sdu_word_t;

    // ======================================================================
    // Channel map
    // ======================================================================

    // Upstream channels: one status feedback, four serial links
    localparam int NUM_CHN = 5;

    // Bit positions in the empty / dval / rden vectors
    // Status feedback on top, slink0 just below it
    localparam int CHN_SFM    = 4;
    localparam int CHN_SLINK0 = 3;
    localparam int CHN_SLINK1 = 2;
    localparam int CHN_SLINK2 = 1;
    localparam int CHN_SLINK3 = 0;

    // Payload bit of a sop word that steers the frame to output FIFO 1
    localparam int DEST_BIT = 15;

endpackage

`default_nettype wire

// ==== rtl/sdu_frame_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module sdu_frame_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  wire                          clk_12_5m,
    input  wire                          reset,
    // Write side, from the scheduler
    input  wire                          wr_en,
    input  wire  rxsdu_pkg::sdu_word_t   wr_data,
    // Read side, from the downstream consumer
    input  wire                          rd_req,
    output logic                         rd_dval,
    output rxsdu_pkg::sdu_word_t         rd_data,
    // Free words, for back-pressure
    output logic [$clog2(FIFO_DEPTH):0]  free_cnt
);

    import rxsdu_pkg::*;

    // Pointer width, depth is a power of two so pointers wrap by themselves
    localparam int          AW        = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] DEPTH_CNT = (AW + 1)'(FIFO_DEPTH);

    // ======================================================================
    // Storage and bookkeeping
    // ======================================================================

    sdu_word_t     mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // Words held, 0..FIFO_DEPTH
    logic [AW:0]   count;

    logic          wr_ok;
    logic          rd_ok;

    // Write ignored when full
    assign wr_ok = wr_en && (count != DEPTH_CNT);
    // Read of an empty FIFO does nothing, no dval
    assign rd_ok = rd_req && (count != '0);

    // Space left, drives the arbiter's room check
    assign free_cnt = DEPTH_CNT - count;

    // ======================================================================
    // Write port
    // ======================================================================

    always_ff @(posedge clk_12_5m) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk_12_5m) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves count alone
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ======================================================================
    // Read port
    // ======================================================================

    // Dval pulse one cycle after an accepted rd_req
    always_ff @(posedge clk_12_5m) begin
        if (reset) begin
            rd_dval <= 1'b0;
        end else begin
            rd_dval <= rd_ok;
        end
    end

    // Read word, valid alongside rd_dval
    always_ff @(posedge clk_12_5m) begin
        if (rd_ok) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sdu_chn_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module sdu_chn_arbiter (
    input  wire                           clk_12_5m,
    input  wire                           reset,
    // Empty levels of the upstream channels
    input  wire  [rxsdu_pkg::NUM_CHN-1:0] chn_empty,
    // A granted word came back
    input  wire                           word_done,
    // That word was the eop
    input  wire                           frame_done,
    // Both output FIFOs can take another word
    input  wire                           room,
    // One-hot read pulse to the channels
    output logic [rxsdu_pkg::NUM_CHN-1:0] rden
);

    import rxsdu_pkg::*;

    localparam int IDX_W = $clog2(NUM_CHN);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } arb_state_t;

    arb_state_t       state;
    // Channel currently holding the grant
    logic [IDX_W-1:0] grant;
    // First channel to look at in the next search
    logic [IDX_W-1:0] rr_ptr;
    logic [IDX_W-1:0] pick;
    logic             pick_vld;
    logic             issue;

    // Search order runs downward, channel 0 wraps to the top
    function automatic logic [IDX_W-1:0] next_chn(input logic [IDX_W-1:0] chn);
        if (chn == '0) begin
            return IDX_W'(NUM_CHN - 1);
        end
        return chn - 1'b1;
    endfunction

    // ======================================================================
    // Round-robin pick
    // ======================================================================

    // First non-empty channel starting at rr_ptr
    always_comb begin
        int idx;
        pick     = rr_ptr;
        pick_vld = 1'b0;
        for (int i = 0; i < NUM_CHN; i++) begin
            idx = int'(rr_ptr) - i;
            if (idx < 0) begin
                idx = idx + NUM_CHN;
            end
            if (!pick_vld && !chn_empty[idx]) begin
                pick     = IDX_W'(idx);
                pick_vld = 1'b1;
            end
        end
    end

    // Read only while the channel has data and both FIFOs have room
    assign issue = (state == ST_ISSUE) && !chn_empty[grant] && room;
    assign rden  = issue ? (NUM_CHN'(1) << grant) : '0;

    // ======================================================================
    // Grant FSM
    // ======================================================================

    always_ff @(posedge clk_12_5m) begin
        if (reset) begin
            state  <= ST_IDLE;
            grant  <= IDX_W'(CHN_SFM);
            rr_ptr <= IDX_W'(CHN_SFM);
        end else begin
            case (state)
                // Wait for any channel with a frame
                ST_IDLE: begin
                    if (pick_vld) begin
                        grant <= pick;
                        state <= ST_ISSUE;
                    end
                end
                // Single read pulse, then one word in flight
                ST_ISSUE: begin
                    if (issue) begin
                        state <= ST_WAIT;
                    end
                end
                // Word returns two cycles after rden
                ST_WAIT: begin
                    if (frame_done) begin
                        // Frame complete, next search starts after this channel
                        rr_ptr <= next_chn(grant);
                        state  <= ST_IDLE;
                    end else if (word_done) begin
                        state <= ST_ISSUE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sdu_5s1.sv ====
`default_nettype none
`timescale 1ns/1ps

module sdu_5s1 #(
    parameter int FIFO_DEPTH = 64
) (
    input  wire                              clk_12_5m,
    input  wire                              reset,
    // Registered word from the selected channel
    input  wire  [rxsdu_pkg::NUM_CHN-1:0]    chn_sdu_dval,
    input  wire  rxsdu_pkg::sdu_word_t       chn_sdu_data,
    input  wire  [rxsdu_pkg::NUM_CHN-1:0]    chn_sdu_empty,
    output wire  [rxsdu_pkg::NUM_CHN-1:0]    sdu_chn_rden,
    // Output FIFO read ports
    input  wire  [1:0]                       fifo_rdreq,
    output wire  [1:0]                       fifo_rd_dval,
    output wire  rxsdu_pkg::sdu_word_t [1:0] fifo_rd_data
);

    import rxsdu_pkg::*;

    localparam int FREE_W = $clog2(FIFO_DEPTH) + 1;
    // Words each output FIFO must have free before the next read
    localparam int ROOM_MIN = 4;

    // A word from the granted channel is present
    logic              word_vld;
    // And it closes the frame
    logic              word_eop;
    // Output FIFO for the present word
    logic              wr_dest;
    // Destination latched from the sop word
    logic              dest_q;
    logic [1:0]        fifo_wr_en;
    logic              room;
    wire  [FREE_W-1:0] fifo_free [2];

    // ======================================================================
    // Word capture and routing
    // ======================================================================

    // Only the granted channel can answer, so any dval bit will do
    assign word_vld = |chn_sdu_dval;
    assign word_eop = word_vld && chn_sdu_data.eop;

    // Sop word decides on the spot, later words follow the latch
    assign wr_dest = chn_sdu_data.sop ? chn_sdu_data.payload[DEST_BIT] : dest_q;

    always_ff @(posedge clk_12_5m) begin
        if (reset) begin
            dest_q <= 1'b0;
        end else if (word_vld && chn_sdu_data.sop) begin
            dest_q <= chn_sdu_data.payload[DEST_BIT];
        end
    end

    // Bit 0 for FIFO 0, bit 1 for FIFO 1
    assign fifo_wr_en = {word_vld & wr_dest, word_vld & ~wr_dest};

    // Back-pressure: the next word may land in either FIFO
    assign room = (fifo_free[0] >= FREE_W'(ROOM_MIN))
               && (fifo_free[1] >= FREE_W'(ROOM_MIN));

    // ======================================================================
    // Read scheduler
    // ======================================================================

    sdu_chn_arbiter arbiter_i (
        .clk_12_5m  (clk_12_5m),
        .reset      (reset),
        .chn_empty  (chn_sdu_empty),
        .word_done  (word_vld),
        .frame_done (word_eop),
        .room       (room),
        .rden       (sdu_chn_rden)
    );

    // ======================================================================
    // Output FIFOs
    // ======================================================================

    // One FIFO per downstream port, same word type on both
    for (genvar g = 0; g < 2; g++) begin : g_out_fifo
        sdu_frame_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) fifo_i (
            .clk_12_5m (clk_12_5m),
            .reset     (reset),
            .wr_en     (fifo_wr_en[g]),
            .wr_data   (chn_sdu_data),
            .rd_req    (fifo_rdreq[g]),
            .rd_dval   (fifo_rd_dval[g]),
            .rd_data   (fifo_rd_data[g]),
            .free_cnt  (fifo_free[g])
        );
    end

endmodule

`default_nettype wire

// ==== rtl/rxsdu.sv ====
`default_nettype none
`timescale 1ns/1ps

module rxsdu #(
    parameter int FIFO_DEPTH = 64
) (
    input  wire                              clk_12_5m,
    input  wire                              reset,
    // Status-feedback channel
    input  wire                              sfm_empty,
    input  wire                              sfm_dval,
    input  wire  rxsdu_pkg::sdu_word_t       sfm_data,
    output logic                             sfm_rdreq,
    // Serial-link channels 0..3
    input  wire  [3:0]                       slink_empty,
    input  wire  [3:0]                       slink_dval,
    input  wire  rxsdu_pkg::sdu_word_t [3:0] slink_data,
    output logic [3:0]                       slink_rdreq,
    // Downstream read ports 0 and 1
    input  wire  [1:0]                       fifo_rdreq,
    output logic [1:0]                       fifo_rd_dval,
    output rxsdu_pkg::sdu_word_t [1:0]       fifo_rd_data
);

    import rxsdu_pkg::*;

    logic [NUM_CHN-1:0] chn_empty;
    logic [NUM_CHN-1:0] dval_vec;
    sdu_word_t          chn_word [NUM_CHN];
    sdu_word_t          sel_word;
    // Registered dval and word into the scheduler
    logic [NUM_CHN-1:0] chn_sdu_dval;
    sdu_word_t          chn_sdu_data;
    logic [NUM_CHN-1:0] sdu_chn_rden;

    // ======================================================================
    // Channel gather
    // ======================================================================

    always_comb begin
        chn_empty[CHN_SFM]    = sfm_empty;
        chn_empty[CHN_SLINK0] = slink_empty[0];
        chn_empty[CHN_SLINK1] = slink_empty[1];
        chn_empty[CHN_SLINK2] = slink_empty[2];
        chn_empty[CHN_SLINK3] = slink_empty[3];

        dval_vec[CHN_SFM]     = sfm_dval;
        dval_vec[CHN_SLINK0]  = slink_dval[0];
        dval_vec[CHN_SLINK1]  = slink_dval[1];
        dval_vec[CHN_SLINK2]  = slink_dval[2];
        dval_vec[CHN_SLINK3]  = slink_dval[3];

        chn_word[CHN_SFM]     = sfm_data;
        chn_word[CHN_SLINK0]  = slink_data[0];
        chn_word[CHN_SLINK1]  = slink_data[1];
        chn_word[CHN_SLINK2]  = slink_data[2];
        chn_word[CHN_SLINK3]  = slink_data[3];
    end

    // One-hot dval picks the word, anything else gives zero
    always_comb begin
        sel_word = '0;
        for (int i = 0; i < NUM_CHN; i++) begin
            if (dval_vec == (NUM_CHN'(1) << i)) begin
                sel_word = chn_word[i];
            end
        end
    end

    always_ff @(posedge clk_12_5m) begin
        if (reset) begin
            chn_sdu_dval <= '0;
        end else begin
            chn_sdu_dval <= dval_vec;
        end
    end

    always_ff @(posedge clk_12_5m) begin
        chn_sdu_data <= sel_word;
    end

    // Read requests back out in channel order
    assign sfm_rdreq   = sdu_chn_rden[CHN_SFM];
    assign slink_rdreq = {sdu_chn_rden[CHN_SLINK3], sdu_chn_rden[CHN_SLINK2],
                          sdu_chn_rden[CHN_SLINK1], sdu_chn_rden[CHN_SLINK0]};

    // ======================================================================
    // Five-to-one scheduler
    // ======================================================================

    sdu_5s1 #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) sdu_5s1_i (
        .clk_12_5m     (clk_12_5m),
        .reset         (reset),
        .chn_sdu_dval  (chn_sdu_dval),
        .chn_sdu_data  (chn_sdu_data),
        .chn_sdu_empty (chn_empty),
        .sdu_chn_rden  (sdu_chn_rden),
        .fifo_rdreq    (fifo_rdreq),
        .fifo_rd_dval  (fifo_rd_dval),
        .fifo_rd_data  (fifo_rd_data)
    );

endmodule

`default_nettype wire

// ==== bench/tb_chn_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_chn_source #(
    parameter int CHN = 0
) (
    input  wire                        clk_12_5m,
    input  wire                        reset,
    // Load strobe from the testbench
    input  wire                        push,
    input  wire  rxsdu_pkg::sdu_word_t push_word,
    // Channel side of the DUT
    input  wire                        rdreq,
    output logic                       empty,
    output logic                       dval,
    output rxsdu_pkg::sdu_word_t       data,
    output logic                       rd_err
);

    import rxsdu_pkg::*;

    sdu_word_t q [$];
    logic      take;
    logic      push_s;
    sdu_word_t word_s;

    // Mid-cycle sample of the read and load strobes
    initial begin
        take   = 1'b0;
        push_s = 1'b0;
        word_s = '0;
        rd_err = 1'b0;
        forever begin
            @(negedge clk_12_5m);
            take   = 1'b0;
            push_s = 1'b0;
            if (!reset) begin
                if (rdreq && empty) begin
                    $display("Channel %0d source got a read request while empty at %0t ns",
                             CHN, $time);
                    rd_err = 1'b1;
                end
                take   = rdreq && !empty;
                push_s = push;
                word_s = push_word;
            end
        end
    end

    // Outputs change 1 ns after the edge, word and dval one cycle after rdreq
    initial begin
        empty = 1'b1;
        dval  = 1'b0;
        data  = '0;
        forever begin
            @(posedge clk_12_5m);
            #1;
            if (reset) begin
                q.delete();
                dval = 1'b0;
                data = '0;
            end else begin
                dval = take;
                if (take) begin
                    data = q.pop_front();
                end
                if (push_s) begin
                    q.push_back(word_s);
                end
            end
            empty = (q.size() == 0);
        end
    end

endmodule

`default_nettype wire

// ==== bench/rxsdu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rxsdu_tb;

    import rxsdu_pkg::*;

    localparam int          FIFO_DEPTH    = 64;
    // Slinks are bench channels 0..3 and status feedback is 4
    localparam int          SFM_IDX       = 4;
    localparam int          MAX_LEN       = 8;
    localparam int          FRAMES_MIX    = 16;
    localparam int          FRAMES_FILL   = 30;
    localparam int          DRAIN_TIMEOUT = 40000;
    localparam int          STALL_TIMEOUT = 20000;
    localparam int          STALL_CYCLES  = 30;
    localparam logic [31:0] SEED          = 32'h84d8_4762;

    logic                    clk_12_5m;
    logic                    reset;
    logic [NUM_CHN-1:0]      push;
    sdu_word_t [NUM_CHN-1:0] push_word;
    wire  [NUM_CHN-1:0]      src_empty;
    wire  [NUM_CHN-1:0]      src_dval;
    wire  [NUM_CHN-1:0]      src_rdreq;
    wire  [NUM_CHN-1:0]      src_err;
    wire  sdu_word_t [NUM_CHN-1:0] src_data;
    logic [1:0]              fifo_rdreq;
    wire  [1:0]              fifo_rd_dval;
    wire  sdu_word_t [1:0]   fifo_rd_data;

    // Words waiting to be loaded, words inside each source, words due per port
    sdu_word_t          load_q  [NUM_CHN][$];
    sdu_word_t          model_q [NUM_CHN][$];
    sdu_word_t          exp_q   [2][$];
    logic               load_en;
    // Consumer mode 0 idle, 1 random reads, 2 read every cycle
    logic [1:0]         cons_mode;
    int                 seq_nxt  [NUM_CHN];
    logic               cur_dest [NUM_CHN];
    logic [2:0]         last_chn [2];
    logic [2:0]         last_idx [2];
    // Fairness bookkeeping per channel since its last frame start
    logic [NUM_CHN-1:0] seen     [NUM_CHN];
    logic [NUM_CHN-1:0] excused  [NUM_CHN];
    logic               started  [NUM_CHN];
    int                 total_words;
    int                 rcv_cnt;

    initial clk_12_5m = 1'b0;
    always #2 clk_12_5m = ~clk_12_5m;

    // ======================================================================
    // Sources and DUT
    // ======================================================================

    for (genvar g = 0; g < NUM_CHN; g++) begin : g_src
        tb_chn_source #(
            .CHN (g)
        ) src_i (
            .clk_12_5m (clk_12_5m),
            .reset     (reset),
            .push      (push[g]),
            .push_word (push_word[g]),
            .rdreq     (src_rdreq[g]),
            .empty     (src_empty[g]),
            .dval      (src_dval[g]),
            .data      (src_data[g]),
            .rd_err    (src_err[g])
        );
    end

    rxsdu #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rxsdu_i (
        .clk_12_5m    (clk_12_5m),
        .reset        (reset),
        .sfm_empty    (src_empty[SFM_IDX]),
        .sfm_dval     (src_dval[SFM_IDX]),
        .sfm_data     (src_data[SFM_IDX]),
        .sfm_rdreq    (src_rdreq[SFM_IDX]),
        .slink_empty  (src_empty[3:0]),
        .slink_dval   (src_dval[3:0]),
        .slink_data   (src_data[3:0]),
        .slink_rdreq  (src_rdreq[3:0]),
        .fifo_rdreq   (fifo_rdreq),
        .fifo_rd_dval (fifo_rd_dval),
        .fifo_rd_data (fifo_rd_data)
    );

    // ======================================================================
    // Reporting and checks
    // ======================================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at %0t ns: %s, got %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    // Payload stamp holds dest or junk, channel, sequence and word index
    task automatic make_frames(input int n);
        int        len;
        logic      dest;
        sdu_word_t w;
        for (int f = 0; f < n; f++) begin
            for (int c = 0; c < NUM_CHN; c++) begin
                len  = int'($urandom % MAX_LEN) + 1;
                dest = 1'($urandom % 2);
                for (int k = 0; k < len; k++) begin
                    w.sop     = (k == 0);
                    w.eop     = (k == len - 1);
                    // Later words carry junk in bit 15 so only the latched dest may steer them
                    w.payload = {(k == 0) ? dest : 1'($urandom), 3'(c),
                                 9'(seq_nxt[c]), 3'(k)};
                    load_q[c].push_back(w);
                end
                seq_nxt[c]++;
                total_words += len;
            end
        end
    endtask

    // A read request takes the next word out of the channel model
    task automatic note_read(input int c);
        sdu_word_t w;
        if (model_q[c].size() == 0) begin
            abort_run($sformatf("Channel %0d was read with no word loaded", c));
        end else begin
            w = model_q[c].pop_front();
            if (w.sop) begin
                cur_dest[c] = w.payload[15];
                // Every other channel served or empty since this one's last frame
                if (started[c]) begin
                    check_val(32'(seen[c] | excused[c] | (NUM_CHN'(1) << c)),
                              32'((1 << NUM_CHN) - 1),
                              $sformatf("fairness, channel %0d served again too soon", c));
                end
                seen[c]    = '0;
                excused[c] = '0;
                started[c] = 1'b1;
                for (int x = 0; x < NUM_CHN; x++) begin
                    seen[x][c] = 1'b1;
                end
            end
            exp_q[cur_dest[c]].push_back(w);
        end
    endtask

    task automatic check_output(input int p, input sdu_word_t a);
        sdu_word_t e;
        int        c;
        if (exp_q[p].size() == 0) begin
            abort_run($sformatf("Port %0d gave a word that was never routed to it", p));
        end else begin
            e = exp_q[p].pop_front();
            check_val(32'(a), 32'(e), $sformatf("port %0d word", p));
            c = int'(a.payload[14:12]);
            // Contiguous frame means same channel and next word index
            if (!a.sop) begin
                check_val(32'(c), 32'(last_chn[p]), "frame channel mid-frame");
                check_val(32'(a.payload[2:0]), 32'(last_idx[p] + 3'd1), "word index");
            end
            last_chn[p] = 3'(c);
            last_idx[p] = a.payload[2:0];
            rcv_cnt++;
        end
    endtask

    // Read strobes and output dval stay low while nothing is stored
    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_12_5m);
            check_val(32'(src_rdreq), 32'd0, "rdreq with sources empty");
            check_val(32'(fifo_rd_dval), 32'd0, "fifo_rd_dval with FIFOs empty");
        end
    endtask

    // ======================================================================
    // Loader, consumer and monitor
    // ======================================================================

    // One word per channel per cycle into the sources
    initial begin
        push      = '0;
        push_word = '0;
        forever begin
            @(posedge clk_12_5m);
            #1;
            for (int c = 0; c < NUM_CHN; c++) begin
                push[c] = 1'b0;
                if (load_en && load_q[c].size() > 0) begin
                    push_word[c] = load_q[c].pop_front();
                    model_q[c].push_back(push_word[c]);
                    push[c] = 1'b1;
                end
            end
        end
    end

    initial begin
        fifo_rdreq = 2'b00;
        forever begin
            @(posedge clk_12_5m);
            #1;
            case (cons_mode)
                2'd1:    fifo_rdreq = 2'($urandom);
                2'd2:    fifo_rdreq = 2'b11;
                default: fifo_rdreq = 2'b00;
            endcase
        end
    end

    // Mid-cycle sampling where every DUT output has settled
    always @(negedge clk_12_5m) begin
        if (src_err != '0) begin
            abort_run("A read request reached an empty channel source");
        end else if (!reset) begin
            for (int c = 0; c < NUM_CHN; c++) begin
                if (src_rdreq[c]) begin
                    note_read(c);
                end
            end
            for (int c = 0; c < NUM_CHN; c++) begin
                for (int x = 0; x < NUM_CHN; x++) begin
                    excused[x][c] = excused[x][c] | src_empty[c];
                end
            end
            for (int p = 0; p < 2; p++) begin
                if (fifo_rd_dval[p]) begin
                    check_output(p, fifo_rd_data[p]);
                end
            end
        end
    end

    // ======================================================================
    // Phases
    // ======================================================================

    task automatic wait_drained(input string phase);
        int n;
        n = 0;
        while (rcv_cnt != total_words) begin
            @(posedge clk_12_5m);
            n++;
            if (n > DRAIN_TIMEOUT) begin
                abort_run($sformatf("Timed out waiting for the %s frames to drain", phase));
            end
        end
        // Nothing more may come out of the output FIFOs
        cons_mode = 2'd2;
        expect_idle(4);
    endtask

    // Reads stop while the sources still hold words
    task automatic wait_stall();
        int n;
        int idle;
        n    = 0;
        idle = 0;
        while (idle < STALL_CYCLES) begin
            @(negedge clk_12_5m);
            if (src_rdreq == '0 && src_empty != '1) begin
                idle++;
            end else begin
                idle = 0;
            end
            n++;
            if (n > STALL_TIMEOUT) begin
                abort_run("Timed out waiting for the output FIFOs to fill");
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset       = 1'b1;
        load_en     = 1'b0;
        cons_mode   = 2'd0;
        total_words = 0;
        rcv_cnt     = 0;
        for (int c = 0; c < NUM_CHN; c++) begin
            seq_nxt[c]     = 0;
            cur_dest[c]    = 1'b0;
            seen[c]        = '0;
            excused[c]     = '0;
            started[c]     = 1'b0;
        end
        last_chn = '{3'd0, 3'd0};
        last_idx = '{3'd0, 3'd0};
        repeat (5) @(posedge clk_12_5m);
        #1;
        reset = 1'b0;

        // Quiet after reset
        expect_idle(8);
        // Reads of the empty FIFOs give no dval
        cons_mode = 2'd2;
        expect_idle(8);
        cons_mode = 2'd0;

        // Mixed traffic with random reads
        make_frames(FRAMES_MIX);
        load_en   = 1'b1;
        cons_mode = 2'd1;
        wait_drained("mixed");

        // Consumer idle until back-pressure stops the scheduler reading
        cons_mode = 2'd0;
        make_frames(FRAMES_FILL);
        wait_stall();
        check_val(32'(exp_q[0].size() >= FIFO_DEPTH - 3 || exp_q[1].size() >= FIFO_DEPTH - 3),
                  32'd1, "one output FIFO near full at stall");
        check_val(32'(exp_q[0].size() <= FIFO_DEPTH && exp_q[1].size() <= FIFO_DEPTH),
                  32'd1, "output FIFO level within depth");
        cons_mode = 2'd1;
        wait_drained("back-pressure");

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rxsdu.f ====
rtl/rxsdu_pkg.sv
rtl/sdu_frame_fifo.sv
rtl/sdu_chn_arbiter.sv
rtl/sdu_5s1.sv
rtl/rxsdu.sv
bench/tb_chn_source.sv
bench/rxsdu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rxsdu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f rxsdu.f \
    --top-module rxsdu_tb -o rxsdu_sim
./obj_dir/rxsdu_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "run_sim.sh: simulation passed"
else
    echo "run_sim.sh: simulation failed, see sim.log"
    exit 1
fi
